//--- dv/decodeStage_tb.sv
// ====================
// Decode stage testbench
// Random and swept instructions against reference
// models of the register file, immediate, control
// and branch resolution, checked by assertions
// ====================
`timescale 1ns/1ps
`include "decode_defs.svh"

module decodeStage_tb;

    import decodePkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int TOTAL_CYCLES = 10 + 8 + 64 + 128 + 256;

    localparam logic [3:0] ARITH_OPS [4] = '{aluAdd, aluSub, aluXor, aluAndn};
    localparam logic [3:0] SHIFT_OPS [4] = '{aluRol, aluSll, aluRor, aluSrl};
    localparam logic [4:0] BRANCH_OPS [8] = '{`OP_J, `OP_JR, `OP_JAL, `OP_JALR,
                                             `OP_BEQZ, `OP_BNEZ, `OP_BLTZ, `OP_BGEZ};

    logic        clk;
    logic        rst;
    logic [15:0] instr;
    logic [15:0] pcInc;
    logic [2:0]  wbRd;
    logic [15:0] wbData;
    logic        wbWrite;
    logic [2:0]  exRd;
    logic [15:0] exData;
    logic        exWrite;
    logic [2:0]  memRd;
    logic [15:0] memData;
    logic        memRegWrite;
    logic [15:0] read1Data;
    logic [15:0] read2Data;
    logic [15:0] immVal;
    aluOpE       aluOp;
    logic        aluSrc;
    logic        regWrite;
    logic        memWrite;
    logic        memRead;
    logic        memToReg;
    logic [2:0]  rdOut;
    logic [15:0] pcNew;
    logic        pcSrc;
    logic        halt;
    logic        err;

    // Shadow registers and expected values
    logic [15:0] shadow [8];
    logic [15:0] expRead1;
    logic [15:0] expRead2;
    logic [15:0] expImm;
    logic [10:0] expCtl;
    logic [2:0]  expDest;
    logic [15:0] expRs;
    logic [16:0] expRedirect;

    logic [31:0] rngState = 32'h90df791a;
    string       testName = "reset";
    int          errors = 0;
    int          vectors = 0;

    decodeStage decodeStage_inst (
        .clk(clk), .rst(rst), .instr(instr), .pcInc(pcInc),
        .wbRd(wbRd), .wbData(wbData), .wbWrite(wbWrite),
        .exRd(exRd), .exData(exData), .exWrite(exWrite),
        .memRd(memRd), .memData(memData), .memRegWrite(memRegWrite),
        .read1Data(read1Data), .read2Data(read2Data), .immVal(immVal),
        .aluOp(aluOp), .aluSrc(aluSrc), .regWrite(regWrite),
        .memWrite(memWrite), .memRead(memRead), .memToReg(memToReg),
        .rdOut(rdOut), .pcNew(pcNew), .pcSrc(pcSrc), .halt(halt), .err(err)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] randWord();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    // Zero, negative or positive data word
    function automatic logic [15:0] pickData();
        logic [31:0] r;
        r = randWord();
        case (r[1:0])
            2'd0:    return 16'h0000;
            2'd1:    return {1'b1, r[30:16]};
            default: return r[31:16];
        endcase
    endfunction

    // Field width and signedness per opcode, then extend
    function automatic logic [15:0] refImm(input logic [15:0] word);
        int          width;
        logic        signExt;
        logic [15:0] mask;
        logic [15:0] field;
        width = 0;
        signExt = 1'b1;
        case (word[15:11])
            `OP_ADDI, `OP_SUBI, `OP_ST, `OP_LD, `OP_STU:
                width = 5;
            `OP_XORI, `OP_ANDNI, `OP_ROLI, `OP_SLLI, `OP_RORI, `OP_SRLI: begin
                width = 5;
                signExt = 1'b0;
            end
            `OP_BEQZ, `OP_BNEZ, `OP_BLTZ, `OP_BGEZ, `OP_LBI, `OP_JR, `OP_JALR:
                width = 8;
            `OP_SLBI: begin
                width = 8;
                signExt = 1'b0;
            end
            `OP_J, `OP_JAL:
                width = 11;
            default:
                width = 0;
        endcase
        mask = (16'd1 << width) - 16'd1;
        field = word & mask;
        if (width > 0 && signExt && field[width-1]) begin
            field = field | ~mask;
        end
        return field;
    endfunction

    // Flags are regWrite, memWrite, memRead, memToReg, aluSrc, halt, err
    function automatic logic [10:0] refControl(input logic [15:0] word);
        logic [1:0] func;
        func = word[1:0];
        case (word[15:11])
            `OP_HALT:           return {7'b0000010, aluPass};
            `OP_SIIC, `OP_RTI:  return {7'b0000001, aluPass};
            `OP_JAL, `OP_JALR:  return {7'b1000000, aluPass};
            `OP_ADDI:           return {7'b1000100, aluAdd};
            `OP_SUBI:           return {7'b1000100, aluSub};
            `OP_XORI:           return {7'b1000100, aluXor};
            `OP_ANDNI:          return {7'b1000100, aluAndn};
            `OP_ST:             return {7'b0100100, aluAdd};
            `OP_LD:             return {7'b1011100, aluAdd};
            `OP_STU:            return {7'b1100100, aluAdd};
            `OP_SLBI:           return {7'b1000100, aluSlbi};
            `OP_ROLI:           return {7'b1000100, aluRol};
            `OP_SLLI:           return {7'b1000100, aluSll};
            `OP_RORI:           return {7'b1000100, aluRor};
            `OP_SRLI:           return {7'b1000100, aluSrl};
            `OP_LBI:            return {7'b1000100, aluLbi};
            `OP_BTR:            return {7'b1000000, aluBtr};
            `OP_RARITH:         return {7'b1000000, ARITH_OPS[func]};
            `OP_RSHIFT:         return {7'b1000000, SHIFT_OPS[func]};
            `OP_SEQ:            return {7'b1000000, aluSeq};
            `OP_SLT:            return {7'b1000000, aluSlt};
            `OP_SLE:            return {7'b1000000, aluSle};
            `OP_SCO:            return {7'b1000000, aluSco};
            // NOP, jumps and branches write nothing
            default:            return {7'b0000000, aluPass};
        endcase
    endfunction

    function automatic logic [2:0] refDest(input logic [15:0] word);
        logic [4:0] op;
        op = word[15:11];
        if (op == `OP_STU || op == `OP_LBI || op == `OP_SLBI)
            return word[10:8];
        else if (op == `OP_JAL || op == `OP_JALR)
            return 3'd7;
        else if (op[4:3] == 2'b11)
            return word[4:2];
        else
            return word[7:5];
    endfunction

    // Returns pcSrc above pcNew
    function automatic logic [16:0] refRedirect(input logic [15:0] word,
            input logic [15:0] pc, input logic [15:0] rsVal, input logic [15:0] imm);
        logic        taken;
        logic [15:0] target;
        taken = 1'b0;
        target = pc + imm;
        case (word[15:11])
            `OP_J, `OP_JAL: taken = 1'b1;
            `OP_JR, `OP_JALR: begin
                taken = 1'b1;
                target = rsVal + imm;
            end
            `OP_BEQZ: taken = (rsVal == 16'd0);
            `OP_BNEZ: taken = (rsVal != 16'd0);
            `OP_BLTZ: taken = ($signed(rsVal) < 0);
            `OP_BGEZ: taken = ($signed(rsVal) >= 0);
            default:  taken = 1'b0;
        endcase
        return {taken, target};
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 8; i++) begin
                shadow[i] <= 16'd0;
            end
        end else if (wbWrite) begin
            shadow[wbRd] <= wbData;
        end
    end

    always_comb begin
        expRead1 = (wbWrite && wbRd == instr[10:8]) ? wbData : shadow[instr[10:8]];
        expRead2 = (wbWrite && wbRd == instr[7:5]) ? wbData : shadow[instr[7:5]];
        expImm = refImm(instr);
        expCtl = refControl(instr);
        expDest = refDest(instr);
        // EX result first, then MEM, then the register file
        if (exWrite && exRd == instr[10:8])
            expRs = exData;
        else if (memRegWrite && memRd == instr[10:8])
            expRs = memData;
        else
            expRs = expRead1;
        expRedirect = refRedirect(instr, pcInc, expRs, expImm);
    end

    task automatic reportMismatch(input string field, input logic [31:0] expVal,
            input logic [31:0] actVal);
        errors++;
        $display("FAIL %s %s expected %h actual %h", testName, field, expVal, actVal);
    endtask

    // Checked on the falling edge, half a cycle after the inputs change
    read1Check: assert property (@(negedge clk) disable iff (rst) read1Data == expRead1)
        else reportMismatch("read1Data", expRead1, read1Data);
    read2Check: assert property (@(negedge clk) disable iff (rst) read2Data == expRead2)
        else reportMismatch("read2Data", expRead2, read2Data);
    immCheck: assert property (@(negedge clk) immVal == expImm)
        else reportMismatch("immVal", expImm, immVal);
    ctlCheck: assert property (@(negedge clk)
        {regWrite, memWrite, memRead, memToReg, aluSrc, halt, err, aluOp} == expCtl)
        else reportMismatch("control", expCtl,
            {regWrite, memWrite, memRead, memToReg, aluSrc, halt, err, aluOp});
    destCheck: assert property (@(negedge clk) rdOut == expDest)
        else reportMismatch("rdOut", expDest, rdOut);
    redirectCheck: assert property (@(negedge clk) {pcSrc, pcNew} == expRedirect)
        else reportMismatch("pcSrc/pcNew", expRedirect, {pcSrc, pcNew});

    // One instruction per cycle with random write-back and forwarding fields
    task automatic stepCycle(input logic [15:0] word, input logic writeOk,
            input logic biasFwd);
        logic [31:0] r;
        logic [31:0] p;
        r = randWord();
        p = randWord();
        @(posedge clk);
        instr <= word;
        pcInc <= p[15:0];
        wbRd <= (biasFwd && r[14]) ? word[10:8] : r[2:0];
        wbData <= pickData();
        wbWrite <= writeOk && r[3];
        exRd <= (biasFwd && r[4]) ? word[10:8] : r[7:5];
        exData <= pickData();
        exWrite <= r[8];
        memRd <= (biasFwd && r[9]) ? word[10:8] : r[12:10];
        memData <= pickData();
        memRegWrite <= r[13];
        vectors++;
    endtask

    initial begin
        logic [31:0] r;
        rst = 1'b1;
        instr = {`OP_NOP, 11'd0};
        pcInc = 16'd0;
        wbRd = 3'd0;
        wbData = 16'd0;
        wbWrite = 1'b0;
        exRd = 3'd0;
        exData = 16'd0;
        exWrite = 1'b0;
        memRd = 3'd0;
        memData = 16'd0;
        memRegWrite = 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        testName = "resetRead";
        for (int i = 0; i < 8; i++) begin
            stepCycle({`OP_NOP, i[2:0], ~i[2:0], 5'd0}, 1'b0, 1'b0);
        end

        // Half the words read the same register on both ports
        testName = "regBypass";
        for (int i = 0; i < 64; i++) begin
            r = randWord();
            stepCycle(r[20] ? {r[15:8], r[10:8], r[4:0]} : r[15:0], 1'b1, 1'b1);
        end

        testName = "decodeSweep";
        for (int op = 0; op < 32; op++) begin
            for (int k = 0; k < 4; k++) begin
                r = randWord();
                stepCycle({op[4:0], r[10:2], k[1:0]}, 1'b1, 1'b0);
            end
        end

        testName = "branchForward";
        for (int i = 0; i < 256; i++) begin
            r = randWord();
            stepCycle({BRANCH_OPS[r[18:16]], r[10:0]}, 1'b1, 1'b1);
        end

        repeat (2) @(posedge clk);
        $display("Closing report: %0d vectors, %0d errors", vectors, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        #((TOTAL_CYCLES + 50) * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, stimulus did not finish",
            TOTAL_CYCLES + 50);
        $display("sim failed");
        $finish;
    end

endmodule

//--- include/decode_defs.svh
// ====================
// Decode stage definitions
// Datapath sizes, register file shape and the
// five-bit opcode map of the WISC instruction set
// ====================
`ifndef DECODE_DEFS_SVH
`define DECODE_DEFS_SVH

// Datapath and register file
`define WORD_W      16
`define REG_CNT     8
`define REG_SEL_W   3
`define OP_W        5

// JAL and JALR write the return address here
`define LINK_REG    3'd7

// Opcode map
`define OP_HALT     5'b00000
`define OP_NOP      5'b00001
`define OP_SIIC     5'b00010
`define OP_RTI      5'b00011
`define OP_J        5'b00100
`define OP_JR       5'b00101
`define OP_JAL      5'b00110
`define OP_JALR     5'b00111
`define OP_ADDI     5'b01000
`define OP_SUBI     5'b01001
`define OP_XORI     5'b01010
`define OP_ANDNI    5'b01011
`define OP_BEQZ     5'b01100
`define OP_BNEZ     5'b01101
`define OP_BLTZ     5'b01110
`define OP_BGEZ     5'b01111
`define OP_ST       5'b10000
`define OP_LD       5'b10001
`define OP_SLBI     5'b10010
`define OP_STU      5'b10011
`define OP_ROLI     5'b10100
`define OP_SLLI     5'b10101
`define OP_RORI     5'b10110
`define OP_SRLI     5'b10111
`define OP_LBI      5'b11000
`define OP_BTR      5'b11001
// R-format groups selected further by func
`define OP_RARITH   5'b11010
`define OP_RSHIFT   5'b11011
`define OP_SEQ      5'b11100
`define OP_SLT      5'b11101
`define OP_SLE      5'b11110
`define OP_SCO      5'b11111

`endif

//--- run.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module decodeStage_tb -Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "sim failed" "$LOG"; then
    exit 1
fi
exit 0

//--- src.f
+incdir+include
verilog/decodePkg.sv
verilog/regFileBypass.sv
verilog/immExtend.sv
verilog/decodeControl.sv
verilog/branchResolve.sv
verilog/decodeStage.sv
dv/decodeStage_tb.sv

//--- verilog/branchResolve.sv
// ====================
// Branch and jump resolution
// Forwards Rs from EX or MEM, tests it against
// zero and forms the redirect target
// ====================
`timescale 1ns/1ps
`include "decode_defs.svh"

module branchResolve (
    input  logic [`WORD_W-1:0]     pcInc,
    input  logic [`REG_SEL_W-1:0]  rsSel,
    input  logic [`WORD_W-1:0]     rsData,
    input  logic [`REG_SEL_W-1:0]  exRd,
    input  logic [`WORD_W-1:0]     exData,
    input  logic                   exWrite,
    input  logic [`REG_SEL_W-1:0]  memRd,
    input  logic [`WORD_W-1:0]     memData,
    input  logic                   memRegWrite,
    input  logic [`WORD_W-1:0]     immVal,
    input  decodePkg::branchKindE  branchKind,
    input  decodePkg::jumpKindE    jumpKind,
    output logic [`WORD_W-1:0]     pcNew,
    output logic                   pcSrc
);

    import decodePkg::*;

    logic [`WORD_W-1:0] rsFwd;
    logic [`WORD_W-1:0] base;
    logic               taken;

    // Youngest producer first
    always_comb begin
        if (exWrite && exRd == rsSel) begin
            rsFwd = exData;
        end else if (memRegWrite && memRd == rsSel) begin
            rsFwd = memData;
        end else begin
            rsFwd = rsData;
        end
    end

    always_comb begin
        case (branchKind)
            branchBeqz: taken = (rsFwd == '0);
            branchBnez: taken = (rsFwd != '0);
            branchBltz: taken = rsFwd[`WORD_W-1];
            branchBgez: taken = !rsFwd[`WORD_W-1];
            default:    taken = 1'b0;
        endcase
    end

    // JR and JALR are relative to Rs, everything else to the next PC
    assign base  = (jumpKind == jumpRegister) ? rsFwd : pcInc;
    assign pcNew = base + immVal;
    assign pcSrc = taken || (jumpKind != jumpNone);

    // Fetch must never be redirected to an unknown address
    always_comb begin
        if (pcSrc) begin
            assert (!$isunknown(pcNew))
                else $error("branchResolve: unknown pcNew while redirecting");
        end
    end

endmodule

//--- verilog/decodeControl.sv
// ====================
// Decode control unit
// Turns the opcode and func field into execute,
// memory and write-back levels, the branch and
// jump kind and the destination register
// ====================
`timescale 1ns/1ps
`include "decode_defs.svh"

module decodeControl (
    input  decodePkg::instrWord      instr,
    output logic                     regWrite,
    output logic                     memWrite,
    output logic                     memRead,
    output logic                     memToReg,
    output logic                     aluSrc,
    output logic                     halt,
    output logic                     err,
    output decodePkg::aluOpE         aluOp,
    output logic [`REG_SEL_W-1:0]    rdOut,
    output decodePkg::branchKindE    branchKind,
    output decodePkg::jumpKindE      jumpKind
);

    import decodePkg::*;

    logic [`OP_W-1:0] opcode;
    logic [1:0]       func;

    assign opcode = instr.rFmt.opcode;
    assign func   = instr.rFmt.func;

    always_comb begin
        regWrite   = 1'b0;
        memWrite   = 1'b0;
        memRead    = 1'b0;
        memToReg   = 1'b0;
        aluSrc     = 1'b0;
        halt       = 1'b0;
        err        = 1'b0;
        aluOp      = aluPass;
        branchKind = branchNone;
        jumpKind   = jumpNone;
        case (opcode)
            `OP_HALT: halt = 1'b1;
            // Not supported by this pipeline so nothing gets written
            `OP_SIIC, `OP_RTI: err = 1'b1;
            `OP_J:  jumpKind = jumpDirect;
            `OP_JR: jumpKind = jumpRegister;
            // Link address arrives on the ALU path unchanged
            `OP_JAL: begin
                jumpKind = jumpDirect;
                regWrite = 1'b1;
            end
            `OP_JALR: begin
                jumpKind = jumpRegister;
                regWrite = 1'b1;
            end
            `OP_ADDI, `OP_SUBI, `OP_XORI, `OP_ANDNI: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                aluOp    = aluOpE'({2'b00, opcode[1:0]});
            end
            `OP_BEQZ: branchKind = branchBeqz;
            `OP_BNEZ: branchKind = branchBnez;
            `OP_BLTZ: branchKind = branchBltz;
            `OP_BGEZ: branchKind = branchBgez;
            `OP_ST: begin
                memWrite = 1'b1;
                aluSrc   = 1'b1;
                aluOp    = aluAdd;
            end
            `OP_LD: begin
                regWrite = 1'b1;
                memRead  = 1'b1;
                memToReg = 1'b1;
                aluSrc   = 1'b1;
                aluOp    = aluAdd;
            end
            // Store with update also writes the new address back to Rs
            `OP_STU: begin
                regWrite = 1'b1;
                memWrite = 1'b1;
                aluSrc   = 1'b1;
                aluOp    = aluAdd;
            end
            `OP_SLBI: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                aluOp    = aluSlbi;
            end
            `OP_ROLI, `OP_SLLI, `OP_RORI, `OP_SRLI: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                aluOp    = aluOpE'({2'b01, opcode[1:0]});
            end
            `OP_LBI: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                aluOp    = aluLbi;
            end
            `OP_BTR: begin
                regWrite = 1'b1;
                aluOp    = aluBtr;
            end
            // func picks ADD, SUB, XOR or ANDN
            `OP_RARITH: begin
                regWrite = 1'b1;
                aluOp    = aluOpE'({2'b00, func});
            end
            // func picks ROL, SLL, ROR or SRL
            `OP_RSHIFT: begin
                regWrite = 1'b1;
                aluOp    = aluOpE'({2'b01, func});
            end
            `OP_SEQ, `OP_SLT, `OP_SLE, `OP_SCO: begin
                regWrite = 1'b1;
                aluOp    = aluOpE'({2'b10, opcode[1:0]});
            end
            default: ;
        endcase
    end

    // Destination register by the first matching rule
    always_comb begin
        if (opcode == `OP_STU || opcode == `OP_LBI || opcode == `OP_SLBI) begin
            rdOut = instr.rFmt.rs;
        end else if (opcode == `OP_JAL || opcode == `OP_JALR) begin
            rdOut = `LINK_REG;
        end else if (opcode[`OP_W-1 -: 2] == 2'b11) begin
            rdOut = instr.rFmt.rd;
        end else begin
            rdOut = instr.rFmt.rt;
        end
    end

endmodule

//--- verilog/decodePkg.sv
// ====================
// Decode stage types
// Instruction word views and the control enums
// shared by the decode blocks
// ====================
`include "decode_defs.svh"

package decodePkg;

    // Register format: two sources, one destination, func
    typedef struct packed {
        logic [`OP_W-1:0]      opcode;
        logic [`REG_SEL_W-1:0] rs;
        logic [`REG_SEL_W-1:0] rt;
        logic [`REG_SEL_W-1:0] rd;
        logic [1:0]            func;
    } rFormat;

    // Five-bit immediate format
    typedef struct packed {
        logic [`OP_W-1:0]      opcode;
        logic [`REG_SEL_W-1:0] rs;
        logic [`REG_SEL_W-1:0] rd;
        logic [4:0]            imm;
    } i1Format;

    // Eight-bit immediate format, also used by branches
    typedef struct packed {
        logic [`OP_W-1:0]      opcode;
        logic [`REG_SEL_W-1:0] rs;
        logic [7:0]            imm;
    } i2Format;

    // PC-relative jump displacement
    typedef struct packed {
        logic [`OP_W-1:0] opcode;
        logic [10:0]      disp;
    } jFormat;

    typedef union packed {
        rFormat  rFmt;
        i1Format i1Fmt;
        i2Format i2Fmt;
        jFormat  jFmt;
    } instrWord;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluXor, aluAndn,
        aluRol, aluSll, aluRor, aluSrl,
        aluSeq, aluSlt, aluSle, aluSco,
        aluBtr, aluLbi, aluSlbi, aluPass
    } aluOpE;

    typedef enum logic [2:0] {
        branchNone, branchBeqz, branchBnez, branchBltz, branchBgez
    } branchKindE;

    // Direct is PC-relative, register is Rs-relative
    typedef enum logic [1:0] {
        jumpNone, jumpDirect, jumpRegister
    } jumpKindE;

endpackage

//--- verilog/decodeStage.sv
// ====================
// Decode stage top
// Register file, control decode, immediate
// extension and branch resolution for the
// five-stage WISC pipeline
// ====================
`timescale 1ns/1ps
`include "decode_defs.svh"

module decodeStage (
    input  logic                   clk,
    input  logic                   rst,
    input  decodePkg::instrWord    instr,
    input  logic [`WORD_W-1:0]     pcInc,
    // Write-back port into the register file
    input  logic [`REG_SEL_W-1:0]  wbRd,
    input  logic [`WORD_W-1:0]     wbData,
    input  logic                   wbWrite,
    // Forwarding sources for branch and jump Rs
    input  logic [`REG_SEL_W-1:0]  exRd,
    input  logic [`WORD_W-1:0]     exData,
    input  logic                   exWrite,
    input  logic [`REG_SEL_W-1:0]  memRd,
    input  logic [`WORD_W-1:0]     memData,
    input  logic                   memRegWrite,
    output logic [`WORD_W-1:0]     read1Data,
    output logic [`WORD_W-1:0]     read2Data,
    output logic [`WORD_W-1:0]     immVal,
    output decodePkg::aluOpE       aluOp,
    output logic                   aluSrc,
    output logic                   regWrite,
    output logic                   memWrite,
    output logic                   memRead,
    output logic                   memToReg,
    output logic [`REG_SEL_W-1:0]  rdOut,
    output logic [`WORD_W-1:0]     pcNew,
    output logic                   pcSrc,
    output logic                   halt,
    output logic                   err
);

    import decodePkg::*;

    branchKindE branchKind;
    jumpKindE   jumpKind;

    regFileBypass regFile_inst (
        .clk       (clk),
        .rst       (rst),
        .read1Sel  (instr.rFmt.rs),
        .read2Sel  (instr.rFmt.rt),
        .writeSel  (wbRd),
        .writeData (wbData),
        .writeEn   (wbWrite),
        .read1Data (read1Data),
        .read2Data (read2Data)
    );

    immExtend immExtend_inst (
        .instr  (instr),
        .immVal (immVal)
    );

    decodeControl decodeControl_inst (
        .instr      (instr),
        .regWrite   (regWrite),
        .memWrite   (memWrite),
        .memRead    (memRead),
        .memToReg   (memToReg),
        .aluSrc     (aluSrc),
        .halt       (halt),
        .err        (err),
        .aluOp      (aluOp),
        .rdOut      (rdOut),
        .branchKind (branchKind),
        .jumpKind   (jumpKind)
    );

    branchResolve branchResolve_inst (
        .pcInc       (pcInc),
        .rsSel       (instr.rFmt.rs),
        .rsData      (read1Data),
        .exRd        (exRd),
        .exData      (exData),
        .exWrite     (exWrite),
        .memRd       (memRd),
        .memData     (memData),
        .memRegWrite (memRegWrite),
        .immVal      (immVal),
        .branchKind  (branchKind),
        .jumpKind    (jumpKind),
        .pcNew       (pcNew),
        .pcSrc       (pcSrc)
    );

endmodule

//--- verilog/immExtend.sv
// ====================
// Immediate extension
// Picks the immediate field for the opcode and
// sign- or zero-extends it to a full word
// ====================
`timescale 1ns/1ps
`include "decode_defs.svh"

module immExtend (
    input  decodePkg::instrWord    instr,
    output logic [`WORD_W-1:0]     immVal
);

    logic [4:0]  imm5;
    logic [7:0]  imm8;
    logic [10:0] disp11;

    assign imm5   = instr.i1Fmt.imm;
    assign imm8   = instr.i2Fmt.imm;
    assign disp11 = instr.jFmt.disp;

    always_comb begin
        case (instr.rFmt.opcode)
            // Arithmetic and memory offsets are signed
            `OP_ADDI, `OP_SUBI, `OP_ST, `OP_LD, `OP_STU:
                immVal = {{(`WORD_W-5){imm5[4]}}, imm5};
            // Logic and shift amounts are unsigned
            `OP_XORI, `OP_ANDNI, `OP_ROLI, `OP_SLLI, `OP_RORI, `OP_SRLI:
                immVal = {{(`WORD_W-5){1'b0}}, imm5};
            `OP_BEQZ, `OP_BNEZ, `OP_BLTZ, `OP_BGEZ, `OP_LBI, `OP_JR, `OP_JALR:
                immVal = {{(`WORD_W-8){imm8[7]}}, imm8};
            // SLBI shifts these bits into the low byte
            `OP_SLBI:
                immVal = {{(`WORD_W-8){1'b0}}, imm8};
            `OP_J, `OP_JAL:
                immVal = {{(`WORD_W-11){disp11[10]}}, disp11};
            default:
                immVal = '0;
        endcase
    end

endmodule

//--- verilog/regFileBypass.sv
// ====================
// Bypassing register file
// Eight word-wide registers, two read ports and one
// write port; a read of the register being written
// returns the incoming data in the same cycle
// ====================
`timescale 1ns/1ps
`include "decode_defs.svh"

module regFileBypass (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`REG_SEL_W-1:0] read1Sel,
    input  logic [`REG_SEL_W-1:0] read2Sel,
    input  logic [`REG_SEL_W-1:0] writeSel,
    input  logic [`WORD_W-1:0]    writeData,
    input  logic                  writeEn,
    output logic [`WORD_W-1:0]    read1Data,
    output logic [`WORD_W-1:0]    read2Data
);

    logic [`WORD_W-1:0] regs [`REG_CNT];
    logic               hit1;
    logic               hit2;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `REG_CNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[writeSel] <= writeData;
        end
    end

    // Same-cycle write wins over the stored value
    assign hit1 = writeEn && (writeSel == read1Sel);
    assign hit2 = writeEn && (writeSel == read2Sel);

    assign read1Data = hit1 ? writeData : regs[read1Sel];
    assign read2Data = hit2 ? writeData : regs[read2Sel];

    // Write-back must not push X into the file or through the bypass
    writeDataKnown: assert property (
        @(posedge clk) disable iff (rst)
        writeEn |-> !$isunknown(writeData)
    ) else $error("regFileBypass: unknown writeData with writeEn set");

endmodule
